//--- common/mem_sys_pkg.sv
package mem_sys_pkg;

  // line geometry
  localparam int data_width     = 64;
  localparam int strb_width     = data_width / 8;
  localparam int line_addr_bits = $clog2(strb_width);

  // dma and core byte address, msb selects imem
  localparam int addr_width = 14;

  typedef logic [data_width-1:0] line_t;
  typedef logic [strb_width-1:0] strb_t;

  // what a bank dma port does in one cycle
  typedef enum logic [1:0] {
    op_idle,
    op_write,
    op_read
  } bank_op_e;

endpackage

//--- common/dma_wr_if.sv
`timescale 1ns/1ps

interface dma_wr_if #(
  parameter int DMEM_ADDR_WIDTH = 13
);
  import mem_sys_pkg::*;

  logic                       valid;
  logic [DMEM_ADDR_WIDTH-1:0] addr;
  strb_t                      strb;
  line_t                      data;
  // request leaves the queue on valid && grant
  logic                       grant;

  modport router (output valid, addr, strb, data, input grant);
  modport memory (input valid, addr, strb, data, output grant);

endinterface

//--- src/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter int DEPTH_LOG = 2,
  parameter int WIDTH     = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic [WIDTH-1:0]     in_data,
  output logic                 in_ready,
  output logic                 out_valid,
  output logic [WIDTH-1:0]     out_data,
  input  logic                 out_ready,
  output logic [DEPTH_LOG:0]   free_slots
);

  localparam int depth = 2 ** DEPTH_LOG;

  logic [WIDTH-1:0]     mem [depth];
  logic [DEPTH_LOG-1:0] wr_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr;
  logic [DEPTH_LOG:0]   count;
  logic                 push;
  logic                 pop;

  assign in_ready   = count != (DEPTH_LOG+1)'(depth);
  assign out_valid  = count != '0;
  assign out_data   = mem[rd_ptr];
  assign free_slots = (DEPTH_LOG+1)'(depth) - count;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

//--- dma_in/dma_cmd_router.sv
`timescale 1ns/1ps

module dma_cmd_router #(
  parameter int IMEM_ADDR_WIDTH    = 13,
  parameter int DMEM_ADDR_WIDTH    = 13,
  parameter int REQ_FIFO_DEPTH_LOG = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 dma_cmd_wr_en,
  input  logic [mem_sys_pkg::addr_width-1:0]   dma_cmd_wr_addr,
  input  mem_sys_pkg::line_t                   dma_cmd_wr_data,
  input  mem_sys_pkg::strb_t                   dma_cmd_wr_strb,
  output logic                                 dma_cmd_wr_ready,
  input  logic                                 dma_cmd_rd_en,
  input  logic [mem_sys_pkg::addr_width-1:0]   dma_cmd_rd_addr,
  output logic                                 dma_cmd_rd_ready,
  output logic                                 imem_wr_en,
  output logic [IMEM_ADDR_WIDTH-1:0]           imem_wr_addr,
  output mem_sys_pkg::strb_t                   imem_wr_strb,
  output mem_sys_pkg::line_t                   imem_wr_data,
  dma_wr_if.router                             dmem_wr,
  output logic                                 rd_valid,
  output logic [DMEM_ADDR_WIDTH-1:0]           rd_addr,
  input  logic                                 rd_grant
);
  import mem_sys_pkg::*;

  localparam int imem_q_width = IMEM_ADDR_WIDTH + strb_width + data_width;
  localparam int dmem_q_width = DMEM_ADDR_WIDTH + strb_width + data_width;

  logic wr_to_imem;
  logic rd_to_dmem;
  logic imem_q_ready;
  logic dmem_q_ready;
  logic wr_take;

  ////////////////////////////////////////////////////////////
  // address decode

  assign wr_to_imem = dma_cmd_wr_addr[addr_width-1];
  // imem has no dma read path, so only dmem reads are queued
  assign rd_to_dmem = !dma_cmd_rd_addr[addr_width-1];

  assign dma_cmd_wr_ready = imem_q_ready && dmem_q_ready;
  assign wr_take          = dma_cmd_wr_en && dma_cmd_wr_ready;

  ////////////////////////////////////////////////////////////
  // request queues

  // imem never stalls a write
  req_fifo #(.DEPTH_LOG(REQ_FIFO_DEPTH_LOG), .WIDTH(imem_q_width)) imem_wr_q (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (wr_take && wr_to_imem),
    .in_data    ({dma_cmd_wr_addr[IMEM_ADDR_WIDTH-1:0], dma_cmd_wr_strb, dma_cmd_wr_data}),
    .in_ready   (imem_q_ready),
    .out_valid  (imem_wr_en),
    .out_data   ({imem_wr_addr, imem_wr_strb, imem_wr_data}),
    .out_ready  (1'b1),
    .free_slots ()
  );

  req_fifo #(.DEPTH_LOG(REQ_FIFO_DEPTH_LOG), .WIDTH(dmem_q_width)) dmem_wr_q (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (wr_take && !wr_to_imem),
    .in_data    ({dma_cmd_wr_addr[DMEM_ADDR_WIDTH-1:0], dma_cmd_wr_strb, dma_cmd_wr_data}),
    .in_ready   (dmem_q_ready),
    .out_valid  (dmem_wr.valid),
    .out_data   ({dmem_wr.addr, dmem_wr.strb, dmem_wr.data}),
    .out_ready  (dmem_wr.grant),
    .free_slots ()
  );

  req_fifo #(.DEPTH_LOG(REQ_FIFO_DEPTH_LOG), .WIDTH(DMEM_ADDR_WIDTH)) dmem_rd_q (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (dma_cmd_rd_en && rd_to_dmem),
    .in_data    (dma_cmd_rd_addr[DMEM_ADDR_WIDTH-1:0]),
    .in_ready   (dma_cmd_rd_ready),
    .out_valid  (rd_valid),
    .out_data   (rd_addr),
    .out_ready  (rd_grant),
    .free_slots ()
  );

endmodule

//--- dmem/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank #(
  parameter int DMEM_ADDR_WIDTH = 13
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         dma_wr_req,
  input  logic                         dma_rd_req,
  input  logic [DMEM_ADDR_WIDTH-1:0]   dma_wr_addr,
  input  logic [DMEM_ADDR_WIDTH-1:0]   dma_rd_addr,
  input  mem_sys_pkg::strb_t           dma_wr_strb,
  input  mem_sys_pkg::line_t           dma_wr_data,
  output mem_sys_pkg::bank_op_e        dma_op,
  output mem_sys_pkg::line_t           dma_rd_data,
  input  logic                         core_en,
  input  mem_sys_pkg::strb_t           core_wen,
  input  logic [DMEM_ADDR_WIDTH-1:0]   core_addr,
  input  mem_sys_pkg::line_t           core_wr_data,
  output mem_sys_pkg::line_t           core_rd_data
);
  import mem_sys_pkg::*;

  // bank bit sits above the byte offset
  localparam int idx_lsb    = line_addr_bits + 1;
  localparam int idx_width  = DMEM_ADDR_WIDTH - idx_lsb;
  localparam int bank_lines = 2 ** idx_width;

  logic [strb_width-1:0][7:0] mem [bank_lines];
  logic [idx_width-1:0]       dma_wr_idx;
  logic [idx_width-1:0]       dma_rd_idx;
  logic [idx_width-1:0]       core_idx;

  assign dma_wr_idx = dma_wr_addr[DMEM_ADDR_WIDTH-1:idx_lsb];
  assign dma_rd_idx = dma_rd_addr[DMEM_ADDR_WIDTH-1:idx_lsb];
  assign core_idx   = core_addr[DMEM_ADDR_WIDTH-1:idx_lsb];

  // dma port, writes win over reads
  always_comb begin
    if (dma_wr_req) begin
      dma_op = op_write;
    end else if (dma_rd_req) begin
      dma_op = op_read;
    end else begin
      dma_op = op_idle;
    end
  end

  // contents stay untouched while in reset
  always_ff @(posedge clk) begin
    for (int b = 0; b < strb_width; b++) begin
      if (!rst && dma_op == op_write && dma_wr_strb[b]) begin
        mem[dma_wr_idx][b] <= dma_wr_data[b*8 +: 8];
      end
      if (!rst && core_en && core_wen[b]) begin
        mem[core_idx][b] <= core_wr_data[b*8 +: 8];
      end
    end
    if (dma_op == op_read) dma_rd_data <= mem[dma_rd_idx];
    // core read is an enable without strobes
    if (core_en && core_wen == '0) core_rd_data <= mem[core_idx];
  end

endmodule

//--- dmem/fast_dmem.sv
`timescale 1ns/1ps

module fast_dmem #(
  parameter int DMEM_ADDR_WIDTH = 13
) (
  input  logic                         clk,
  input  logic                         rst,
  dma_wr_if.memory                     dmem_wr,
  input  logic                         rd_valid,
  input  logic [DMEM_ADDR_WIDTH-1:0]   rd_addr,
  output logic                         rd_grant,
  input  logic                         rd_credit,
  output logic                         rd_data_valid,
  output mem_sys_pkg::line_t           rd_data,
  input  logic                         core_dmem_en,
  input  mem_sys_pkg::strb_t           core_dmem_wen,
  input  logic [DMEM_ADDR_WIDTH-1:0]   core_dmem_addr,
  input  mem_sys_pkg::line_t           core_dmem_wr_data,
  output mem_sys_pkg::line_t           core_dmem_rd_data,
  output logic                         core_dmem_rd_valid
);
  import mem_sys_pkg::*;

  bank_op_e op [2];
  line_t    dma_data [2];
  line_t    core_data [2];
  logic     rd_bank_r;
  logic     core_bank_r;

  ////////////////////////////////////////////////////////////
  // bank steering on the line bit

  for (genvar i = 0; i < 2; i++) begin : bank
    dmem_bank #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) u_bank (
      .clk          (clk),
      .rst          (rst),
      .dma_wr_req   (dmem_wr.valid && dmem_wr.addr[line_addr_bits] == 1'(i)),
      .dma_rd_req   (rd_valid && rd_credit && rd_addr[line_addr_bits] == 1'(i)),
      .dma_wr_addr  (dmem_wr.addr),
      .dma_rd_addr  (rd_addr),
      .dma_wr_strb  (dmem_wr.strb),
      .dma_wr_data  (dmem_wr.data),
      .dma_op       (op[i]),
      .dma_rd_data  (dma_data[i]),
      .core_en      (core_dmem_en && core_dmem_addr[line_addr_bits] == 1'(i)),
      .core_wen     (core_dmem_wen),
      .core_addr    (core_dmem_addr),
      .core_wr_data (core_dmem_wr_data),
      .core_rd_data (core_data[i])
    );
  end

  assign dmem_wr.grant = op[0] == op_write || op[1] == op_write;
  assign rd_grant      = op[0] == op_read || op[1] == op_read;

  ////////////////////////////////////////////////////////////
  // read return

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_valid      <= 1'b0;
      core_dmem_rd_valid <= 1'b0;
    end else begin
      rd_data_valid      <= rd_grant;
      core_dmem_rd_valid <= core_dmem_en && core_dmem_wen == '0;
    end
    rd_bank_r   <= rd_addr[line_addr_bits];
    core_bank_r <= core_dmem_addr[line_addr_bits];
  end

  assign rd_data           = rd_bank_r ? dma_data[1] : dma_data[0];
  assign core_dmem_rd_data = core_bank_r ? core_data[1] : core_data[0];

endmodule

//--- src/imem.sv
`timescale 1ns/1ps

module imem #(
  parameter int IMEM_ADDR_WIDTH = 13
) (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [IMEM_ADDR_WIDTH-1:0]   wr_addr,
  input  mem_sys_pkg::strb_t           wr_strb,
  input  mem_sys_pkg::line_t           wr_data,
  input  logic                         rd_en,
  input  logic [IMEM_ADDR_WIDTH-1:0]   rd_addr,
  output mem_sys_pkg::line_t           rd_data
);
  import mem_sys_pkg::*;

  localparam int lines = 2 ** (IMEM_ADDR_WIDTH - line_addr_bits);

  logic [strb_width-1:0][7:0] mem [lines];

  always_ff @(posedge clk) begin
    for (int b = 0; b < strb_width; b++) begin
      if (wr_en && wr_strb[b]) begin
        mem[wr_addr[IMEM_ADDR_WIDTH-1:line_addr_bits]][b] <= wr_data[b*8 +: 8];
      end
    end
    // registered read, one cycle after rd_en
    if (rd_en) rd_data <= mem[rd_addr[IMEM_ADDR_WIDTH-1:line_addr_bits]];
  end

endmodule

//--- src/dma_rd_resp.sv
`timescale 1ns/1ps

module dma_rd_resp #(
  parameter int RESP_FIFO_DEPTH_LOG = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_data_valid,
  input  mem_sys_pkg::line_t   rd_data,
  output logic                 rd_credit,
  output logic                 dma_rd_resp_valid,
  output mem_sys_pkg::line_t   dma_rd_resp_data,
  input  logic                 dma_rd_resp_ready
);
  import mem_sys_pkg::*;

  logic [RESP_FIFO_DEPTH_LOG:0] free_slots;

  // credit guarantees room, so in_ready is never low on a push
  req_fifo #(.DEPTH_LOG(RESP_FIFO_DEPTH_LOG), .WIDTH(data_width)) resp_q (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (rd_data_valid),
    .in_data    (rd_data),
    .in_ready   (),
    .out_valid  (dma_rd_resp_valid),
    .out_data   (dma_rd_resp_data),
    .out_ready  (dma_rd_resp_ready),
    .free_slots (free_slots)
  );

  // one entry held back for the read granted last cycle
  assign rd_credit = free_slots >= 2;

endmodule

//--- src/mem_sys.sv
`timescale 1ns/1ps

module mem_sys #(
  parameter int IMEM_ADDR_WIDTH     = 13,
  parameter int DMEM_ADDR_WIDTH     = 13,
  parameter int REQ_FIFO_DEPTH_LOG  = 2,
  parameter int RESP_FIFO_DEPTH_LOG = 3
) (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic                                 dma_cmd_wr_en,
  input  logic [mem_sys_pkg::addr_width-1:0]   dma_cmd_wr_addr,
  input  mem_sys_pkg::line_t                   dma_cmd_wr_data,
  input  mem_sys_pkg::strb_t                   dma_cmd_wr_strb,
  input  logic                                 dma_cmd_wr_last,
  output logic                                 dma_cmd_wr_ready,

  input  logic                                 dma_cmd_rd_en,
  input  logic [mem_sys_pkg::addr_width-1:0]   dma_cmd_rd_addr,
  input  logic                                 dma_cmd_rd_last,
  output logic                                 dma_cmd_rd_ready,

  output logic                                 dma_rd_resp_valid,
  output mem_sys_pkg::line_t                   dma_rd_resp_data,
  input  logic                                 dma_rd_resp_ready,

  input  logic                                 core_dmem_en,
  input  mem_sys_pkg::strb_t                   core_dmem_wen,
  input  logic [mem_sys_pkg::addr_width-1:0]   core_dmem_addr,
  input  mem_sys_pkg::line_t                   core_dmem_wr_data,
  output mem_sys_pkg::line_t                   core_dmem_rd_data,
  output logic                                 core_dmem_rd_valid,

  input  logic                                 core_imem_ren,
  input  logic [mem_sys_pkg::addr_width-1:0]   core_imem_addr,
  output mem_sys_pkg::line_t                   core_imem_rd_data
);
  import mem_sys_pkg::*;

  logic                       imem_wr_en;
  logic [IMEM_ADDR_WIDTH-1:0] imem_wr_addr;
  strb_t                      imem_wr_strb;
  line_t                      imem_wr_data;
  logic                       rd_valid;
  logic [DMEM_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_grant;
  logic                       rd_credit;
  logic                       rd_data_valid;
  line_t                      rd_data;

  dma_wr_if #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) dmem_wr ();

  // last flags carry no meaning for single-line commands
  dma_cmd_router #(
    .IMEM_ADDR_WIDTH    (IMEM_ADDR_WIDTH),
    .DMEM_ADDR_WIDTH    (DMEM_ADDR_WIDTH),
    .REQ_FIFO_DEPTH_LOG (REQ_FIFO_DEPTH_LOG)
  ) u_router (
    .clk              (clk),
    .rst              (rst),
    .dma_cmd_wr_en    (dma_cmd_wr_en),
    .dma_cmd_wr_addr  (dma_cmd_wr_addr),
    .dma_cmd_wr_data  (dma_cmd_wr_data),
    .dma_cmd_wr_strb  (dma_cmd_wr_strb),
    .dma_cmd_wr_ready (dma_cmd_wr_ready),
    .dma_cmd_rd_en    (dma_cmd_rd_en),
    .dma_cmd_rd_addr  (dma_cmd_rd_addr),
    .dma_cmd_rd_ready (dma_cmd_rd_ready),
    .imem_wr_en       (imem_wr_en),
    .imem_wr_addr     (imem_wr_addr),
    .imem_wr_strb     (imem_wr_strb),
    .imem_wr_data     (imem_wr_data),
    .dmem_wr          (dmem_wr),
    .rd_valid         (rd_valid),
    .rd_addr          (rd_addr),
    .rd_grant         (rd_grant)
  );

  fast_dmem #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) u_dmem (
    .clk                (clk),
    .rst                (rst),
    .dmem_wr            (dmem_wr),
    .rd_valid           (rd_valid),
    .rd_addr            (rd_addr),
    .rd_grant           (rd_grant),
    .rd_credit          (rd_credit),
    .rd_data_valid      (rd_data_valid),
    .rd_data            (rd_data),
    .core_dmem_en       (core_dmem_en),
    .core_dmem_wen      (core_dmem_wen),
    .core_dmem_addr     (core_dmem_addr[DMEM_ADDR_WIDTH-1:0]),
    .core_dmem_wr_data  (core_dmem_wr_data),
    .core_dmem_rd_data  (core_dmem_rd_data),
    .core_dmem_rd_valid (core_dmem_rd_valid)
  );

  imem #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_imem (
    .clk     (clk),
    .wr_en   (imem_wr_en),
    .wr_addr (imem_wr_addr),
    .wr_strb (imem_wr_strb),
    .wr_data (imem_wr_data),
    .rd_en   (core_imem_ren),
    .rd_addr (core_imem_addr[IMEM_ADDR_WIDTH-1:0]),
    .rd_data (core_imem_rd_data)
  );

  dma_rd_resp #(.RESP_FIFO_DEPTH_LOG(RESP_FIFO_DEPTH_LOG)) u_rd_resp (
    .clk               (clk),
    .rst               (rst),
    .rd_data_valid     (rd_data_valid),
    .rd_data           (rd_data),
    .rd_credit         (rd_credit),
    .dma_rd_resp_valid (dma_rd_resp_valid),
    .dma_rd_resp_data  (dma_rd_resp_data),
    .dma_rd_resp_ready (dma_rd_resp_ready)
  );

endmodule

//--- tests/mem_sys_chk.sv
`timescale 1ns/1ps

module mem_sys_chk (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dma_rd_resp_valid,
  input  mem_sys_pkg::line_t   dma_rd_resp_data,
  input  logic                 dma_rd_resp_ready,
  input  logic                 core_dmem_en,
  input  mem_sys_pkg::strb_t   core_dmem_wen,
  input  logic                 core_dmem_rd_valid
);
  import mem_sys_pkg::*;

  int err_count = 0;

  // registered valids come out of reset low
  reset_low: assert property (@(posedge clk) rst |=> !dma_rd_resp_valid && !core_dmem_rd_valid)
    else begin
      err_count++;
      $error("response or core read valid high right after reset");
    end

  // stalled response keeps its beat
  resp_hold: assert property (@(posedge clk) disable iff (rst)
    dma_rd_resp_valid && !dma_rd_resp_ready |=> dma_rd_resp_valid && $stable(dma_rd_resp_data))
    else begin
      err_count++;
      $error("read response dropped or changed while stalled");
    end

  core_rd_valid_on: assert property (@(posedge clk) disable iff (rst)
    core_dmem_en && core_dmem_wen == '0 |=> core_dmem_rd_valid)
    else begin
      err_count++;
      $error("core read valid missing one cycle after a core read");
    end

  core_rd_valid_off: assert property (@(posedge clk) disable iff (rst)
    !(core_dmem_en && core_dmem_wen == '0) |=> !core_dmem_rd_valid)
    else begin
      err_count++;
      $error("core read valid high without a core read");
    end

endmodule

//--- tests/mem_sys_tb.sv
`timescale 1ns/1ps

module mem_sys_tb;
  import mem_sys_pkg::*;

  // stimulus runs about a thousand cycles, this leaves a wide margin
  localparam int max_cycles = 20000;
  localparam int dma_lines  = 16;
  localparam int core_lines = 8;
  localparam int line_bits  = addr_width - 1 - line_addr_bits;
  // response queue and read request queue depths
  localparam int resp_depth = 2 ** 3;
  localparam int req_depth  = 2 ** 2;

  logic                  clk;
  logic                  rst;
  logic                  dma_cmd_wr_en;
  logic [addr_width-1:0] dma_cmd_wr_addr;
  line_t                 dma_cmd_wr_data;
  strb_t                 dma_cmd_wr_strb;
  logic                  dma_cmd_wr_last;
  logic                  dma_cmd_wr_ready;
  logic                  dma_cmd_rd_en;
  logic [addr_width-1:0] dma_cmd_rd_addr;
  logic                  dma_cmd_rd_last;
  logic                  dma_cmd_rd_ready;
  logic                  dma_rd_resp_valid;
  line_t                 dma_rd_resp_data;
  logic                  dma_rd_resp_ready;
  logic                  core_dmem_en;
  strb_t                 core_dmem_wen;
  logic [addr_width-1:0] core_dmem_addr;
  line_t                 core_dmem_wr_data;
  line_t                 core_dmem_rd_data;
  logic                  core_dmem_rd_valid;
  logic                  core_imem_ren;
  logic [addr_width-1:0] core_imem_addr;
  line_t                 core_imem_rd_data;

  // reference byte arrays, one entry per byte
  logic [7:0]  dmem_ref [8192];
  logic [7:0]  imem_ref [8192];
  line_t       exp_q [$];
  logic [31:0] seed;
  logic [31:0] rdy_seed;
  int          cycles = 0;
  int          rd_count = 0;
  int          resp_count = 0;
  int          hold_left = 0;
  int          stall_base = 0;
  int          first_full = -1;
  int          dma_line [dma_lines];

  mem_sys uut (.*);

  bind mem_sys mem_sys_chk u_chk (
    .clk                (clk),
    .rst                (rst),
    .dma_rd_resp_valid  (dma_rd_resp_valid),
    .dma_rd_resp_data   (dma_rd_resp_data),
    .dma_rd_resp_ready  (dma_rd_resp_ready),
    .core_dmem_en       (core_dmem_en),
    .core_dmem_wen      (core_dmem_wen),
    .core_dmem_rd_valid (core_dmem_rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random numbers and reference model

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    l[63:32] = next_rand();
    l[31:0]  = next_rand();
    return l;
  endfunction

  function automatic strb_t rand_strb();
    logic [31:0] r;
    r = next_rand();
    return r[strb_width-1:0];
  endfunction

  // random byte offset, the line is what matters
  function automatic logic [addr_width-1:0] byte_addr(input bit to_imem, input int line);
    logic [31:0] r;
    r = next_rand();
    return {to_imem, line[line_bits-1:0], r[line_addr_bits-1:0]};
  endfunction

  function automatic line_t ref_line(input bit to_imem, input int line);
    line_t l;
    for (int b = 0; b < strb_width; b++) begin
      l[b*8 +: 8] = to_imem ? imem_ref[line*strb_width + b] : dmem_ref[line*strb_width + b];
    end
    return l;
  endfunction

  task automatic ref_write(input bit to_imem, input int line, input strb_t strb, input line_t data);
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b] && to_imem) imem_ref[line*strb_width + b] = data[b*8 +: 8];
      if (strb[b] && !to_imem) dmem_ref[line*strb_width + b] = data[b*8 +: 8];
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_line(input string what, input line_t got, input line_t exp);
    assert (got === exp) else
      abort_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // cycle stepping, response side handled every cycle

  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (hold_left > 0) begin
      hold_left--;
      dma_rd_resp_ready = 1'b0;
    end else begin
      rdy_seed = xorshift(rdy_seed);
      dma_rd_resp_ready = rdy_seed[1:0] != 2'b00;
    end
    // beat moves at the coming edge
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      assert (exp_q.size() > 0) else abort_run("read response arrived with no read outstanding");
      check_line("dma read response", dma_rd_resp_data, exp_q.pop_front());
      resp_count++;
    end
  endtask

  task automatic dma_write(input bit to_imem, input int line, input strb_t strb, input line_t data);
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr_addr = byte_addr(to_imem, line);
    dma_cmd_wr_strb = strb;
    dma_cmd_wr_data = data;
    while (!dma_cmd_wr_ready) step_cycle();
    step_cycle();
    dma_cmd_wr_en = 1'b0;
    ref_write(to_imem, line, strb, data);
  endtask

  task automatic dma_read(input int line);
    dma_cmd_rd_en   = 1'b1;
    dma_cmd_rd_addr = byte_addr(1'b0, line);
    while (!dma_cmd_rd_ready) begin
      if (first_full < 0) first_full = rd_count - stall_base;
      step_cycle();
    end
    exp_q.push_back(ref_line(1'b0, line));
    rd_count++;
    step_cycle();
    dma_cmd_rd_en = 1'b0;
  endtask

  task automatic drain_reads();
    while (resp_count != rd_count) step_cycle();
  endtask

  task automatic core_access(input int line, input strb_t wen, input line_t data);
    line_t exp;
    exp               = ref_line(1'b0, line);
    core_dmem_en      = 1'b1;
    core_dmem_wen     = wen;
    core_dmem_addr    = byte_addr(1'b0, line);
    core_dmem_wr_data = data;
    step_cycle();
    core_dmem_en  = 1'b0;
    core_dmem_wen = '0;
    assert (core_dmem_rd_valid === (wen == '0)) else
      abort_run($sformatf("MISMATCH at %0d ns: core_dmem_rd_valid is %b, wen was %h",
                          $time, core_dmem_rd_valid, wen));
    if (wen == '0) check_line("core data read", core_dmem_rd_data, exp);
    else ref_write(1'b0, line, wen, data);
  endtask

  task automatic imem_read(input int line);
    core_imem_ren  = 1'b1;
    core_imem_addr = byte_addr(1'b1, line);
    step_cycle();
    core_imem_ren = 1'b0;
    check_line("core instruction read", core_imem_rd_data, ref_line(1'b1, line));
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog

  initial begin
    forever begin
      @(posedge clk);
      #1;
      cycles++;
      if (uut.u_chk.err_count != 0) abort_run("a protocol assertion in mem_sys_chk failed");
      if (cycles >= max_cycles) abort_run("timeout: the run did not finish in time");
    end
  end

  initial begin
    int line;
    seed              = 32'hf501;
    rdy_seed          = xorshift(32'hf501);
    rst               = 1'b1;
    dma_cmd_wr_en     = 1'b0;
    dma_cmd_wr_addr   = '0;
    dma_cmd_wr_data   = '0;
    dma_cmd_wr_strb   = '0;
    dma_cmd_wr_last   = 1'b1;
    dma_cmd_rd_en     = 1'b0;
    dma_cmd_rd_addr   = '0;
    dma_cmd_rd_last   = 1'b1;
    dma_rd_resp_ready = 1'b0;
    core_dmem_en      = 1'b0;
    core_dmem_wen     = '0;
    core_dmem_addr    = '0;
    core_dmem_wr_data = '0;
    core_imem_ren     = 1'b0;
    core_imem_addr    = '0;
    // dma lines live in the lower half of data memory, spread over both banks
    for (int i = 0; i < dma_lines; i++) dma_line[i] = i*32 + int'(next_rand() % 32);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // empty queues take commands
    assert (dma_cmd_wr_ready === 1'b1 && dma_cmd_rd_ready === 1'b1) else
      abort_run($sformatf("MISMATCH at %0d ns: after reset wr_ready is %b, rd_ready is %b",
                          $time, dma_cmd_wr_ready, dma_cmd_rd_ready));

    // full line writes, read back under random ready
    for (int i = 0; i < dma_lines; i++) dma_write(1'b0, dma_line[i], '1, rand_line());
    for (int i = 0; i < dma_lines; i++) dma_read(dma_line[i]);
    drain_reads();

    // partial writes merge bytes
    for (int i = 0; i < dma_lines; i++) dma_write(1'b0, dma_line[i], rand_strb(), rand_line());
    for (int i = 0; i < dma_lines; i++) dma_read(dma_line[i]);
    drain_reads();

    // instruction memory
    for (int i = 0; i < dma_lines; i++) dma_write(1'b1, dma_line[i], '1, rand_line());
    for (int i = 0; i < dma_lines; i++) dma_write(1'b1, dma_line[i], rand_strb(), rand_line());
    repeat (2) step_cycle();
    for (int i = 0; i < dma_lines; i++) imem_read(dma_line[i]);

    // core data port, upper half lines
    for (int i = 0; i < core_lines; i++) begin
      line = 512 + i*64 + int'(next_rand() % 64);
      core_access(line, '1, rand_line());
      core_access(line, rand_strb() | strb_t'(1), rand_line());
      core_access(line, '0, '0);
    end
    for (int i = 0; i < dma_lines; i++) core_access(dma_line[i], '0, '0);

    // long stall on the response side
    hold_left  = 80;
    stall_base = rd_count;
    first_full = -1;
    for (int i = 0; i < 24; i++) dma_read(dma_line[i % dma_lines]);
    drain_reads();
    repeat (10) step_cycle();
    assert (resp_count == rd_count && exp_q.size() == 0 && !dma_rd_resp_valid) else
      abort_run($sformatf("MISMATCH at %0d ns: got %0d read responses for %0d accepted reads",
                          $time, resp_count, rd_count));
    // response queue fills first, then the request queue behind it
    assert (first_full == resp_depth + req_depth) else
      abort_run($sformatf("MISMATCH at %0d ns: rd_ready dropped after %0d reads, expected %0d",
                          $time, first_full, resp_depth + req_depth));

    if (uut.u_chk.err_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("a protocol assertion in mem_sys_chk failed");
    end
  end

endmodule

//--- mem_sys.f
common/mem_sys_pkg.sv
common/dma_wr_if.sv
src/req_fifo.sv
dma_in/dma_cmd_router.sv
dmem/dmem_bank.sv
dmem/fast_dmem.sv
src/imem.sv
src/dma_rd_resp.sv
src/mem_sys.sv
tests/mem_sys_chk.sv
tests/mem_sys_tb.sv

//--- Bender.yml
package:
  name: mem_sys

sources:
  - common/mem_sys_pkg.sv
  - common/dma_wr_if.sv
  - src/req_fifo.sv
  - dma_in/dma_cmd_router.sv
  - dmem/dmem_bank.sv
  - dmem/fast_dmem.sv
  - src/imem.sv
  - src/dma_rd_resp.sv
  - src/mem_sys.sv
  - target: test
    files:
      - tests/mem_sys_chk.sv
      - tests/mem_sys_tb.sv
